// ==== source/l2_axi_defines.svh ====
// Sizing macros for the L2-to-AXI bridge, included by the package and the RTL that needs them
`ifndef L2_AXI_DEFINES_SVH
`define L2_AXI_DEFINES_SVH

// queue entries, also the number of credits the requester starts with
`define L2_QUEUE_DEPTH 4

// request id width, carried on arid and rid
`define L2_ID_W 4

// burst length field, beats minus one
`define L2_BURST_W 4

`endif

// ==== source/l2_axi_pkg.sv ====
// Shared data, address, id and atomic opcode types for the L2-to-AXI bridge RTL
`include "l2_axi_defines.svh"

package l2_axi_pkg;

    // one memory word
    typedef logic [31:0] word_t;

    // word address, byte address is this with two zero bits appended
    typedef logic [29:0] word_addr_t;

    typedef logic [`L2_ID_W-1:0] l2_id_t;

    // atomic operations
    typedef enum logic [3:0] {
        amo_swap = 4'd0,
        amo_add  = 4'd1,
        amo_and  = 4'd2,
        amo_or   = 4'd3,
        amo_xor  = 4'd4,
        amo_min  = 4'd5,
        amo_max  = 4'd6,
        amo_minu = 4'd7,
        amo_maxu = 4'd8
    } amo_op_t;

    // control field: opcode for atomics, beats minus one for plain reads
    typedef union packed {
        amo_op_t                 amo_op;
        logic [`L2_BURST_W-1:0]  burst_len;
    } req_ctrl_u;

endpackage

// ==== source/l2_request_queue.sv ====
// Credit-controlled request queue, first pipeline stage between the L2 arbiter and the AXI issue stage
`include "l2_axi_defines.svh"

module l2_request_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_rnw,
    input  logic                   req_is_amo,
    input  l2_axi_pkg::word_addr_t req_addr,
    input  l2_axi_pkg::req_ctrl_u  req_ctrl,
    input  l2_axi_pkg::word_t      req_wdata,
    input  logic [3:0]             req_be,
    input  l2_axi_pkg::l2_id_t     req_id,
    input  logic                   pop,
    output logic                   head_valid,
    output logic                   head_rnw,
    output logic                   head_is_amo,
    output l2_axi_pkg::word_addr_t head_addr,
    output l2_axi_pkg::req_ctrl_u  head_ctrl,
    output l2_axi_pkg::word_t      head_wdata,
    output logic [3:0]             head_be,
    output l2_axi_pkg::l2_id_t     head_id,
    output logic                   credit_return
);
    localparam int depth = `L2_QUEUE_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic                   rnw_mem    [depth];
    logic                   is_amo_mem [depth];
    l2_axi_pkg::word_addr_t addr_mem   [depth];
    l2_axi_pkg::req_ctrl_u  ctrl_mem   [depth];
    l2_axi_pkg::word_t      wdata_mem  [depth];
    logic [3:0]             be_mem     [depth];
    l2_axi_pkg::l2_id_t     id_mem     [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;

    // wraps at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rnw_mem[wr_ptr]    <= req_rnw;
            is_amo_mem[wr_ptr] <= req_is_amo;
            addr_mem[wr_ptr]   <= req_addr;
            ctrl_mem[wr_ptr]   <= req_ctrl;
            wdata_mem[wr_ptr]  <= req_wdata;
            be_mem[wr_ptr]     <= req_be;
            id_mem[wr_ptr]     <= req_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            // one credit back per popped entry
            credit_return <= pop;
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (req_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!req_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head_valid  = (count != '0);
    assign head_rnw    = rnw_mem[rd_ptr];
    assign head_is_amo = is_amo_mem[rd_ptr];
    assign head_addr   = addr_mem[rd_ptr];
    assign head_ctrl   = ctrl_mem[rd_ptr];
    assign head_wdata  = wdata_mem[rd_ptr];
    assign head_be     = be_mem[rd_ptr];
    assign head_id     = id_mem[rd_ptr];

    // requester must respect credits, issue stage must only pop a valid head
    queue_no_overflow_underflow: assert property (@(posedge clk) disable iff (rst)
        !(req_valid && !pop && count == (ptr_w + 1)'(depth)) && !(pop && count == '0));

endmodule

// ==== source/amo_alu.sv ====
// Combinational atomic arithmetic, computes the word an AMO writes back to memory
module amo_alu (
    input  l2_axi_pkg::amo_op_t op,
    input  l2_axi_pkg::word_t   loaded,
    input  l2_axi_pkg::word_t   operand,
    output l2_axi_pkg::word_t   result
);
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = ($signed(loaded) < $signed(operand));
    assign lt_unsigned = (loaded < operand);

    always_comb begin
        case (op)
            l2_axi_pkg::amo_swap: result = operand;
            l2_axi_pkg::amo_add:  result = loaded + operand;
            l2_axi_pkg::amo_and:  result = loaded & operand;
            l2_axi_pkg::amo_or:   result = loaded | operand;
            l2_axi_pkg::amo_xor:  result = loaded ^ operand;
            // keep the smaller or larger of memory and operand
            l2_axi_pkg::amo_min:  result = lt_signed ? loaded : operand;
            l2_axi_pkg::amo_max:  result = lt_signed ? operand : loaded;
            l2_axi_pkg::amo_minu: result = lt_unsigned ? loaded : operand;
            l2_axi_pkg::amo_maxu: result = lt_unsigned ? operand : loaded;
            // undefined opcodes behave as swap
            default:              result = operand;
        endcase
    end

endmodule

// ==== source/l2_axi_issue.sv ====
// Second pipeline stage of the L2-to-AXI bridge that turns queued L2 requests into AXI transactions
`include "l2_axi_defines.svh"

module l2_axi_issue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   head_valid,
    input  logic                   head_rnw,
    input  logic                   head_is_amo,
    input  l2_axi_pkg::word_addr_t head_addr,
    input  l2_axi_pkg::req_ctrl_u  head_ctrl,
    input  l2_axi_pkg::word_t      head_wdata,
    input  logic [3:0]             head_be,
    input  l2_axi_pkg::l2_id_t     head_id,
    output logic                   pop,
    input  logic                   arready,
    output logic                   arvalid,
    output logic [31:0]            araddr,
    output logic [7:0]             arlen,
    output l2_axi_pkg::l2_id_t     arid,
    input  logic                   rvalid,
    input  l2_axi_pkg::word_t      rdata,
    input  l2_axi_pkg::l2_id_t     rid,
    input  logic                   rlast,
    input  logic                   awready,
    output logic                   awvalid,
    output logic [31:0]            awaddr,
    output logic [7:0]             awlen,
    input  logic                   wready,
    output logic                   wvalid,
    output l2_axi_pkg::word_t      wdata,
    output logic [3:0]             wstrb,
    output logic                   wlast,
    input  logic                   bvalid,
    output logic                   rd_valid,
    output l2_axi_pkg::word_t      rd_data,
    output l2_axi_pkg::l2_id_t     rd_id,
    output logic                   rd_last
);
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_ar       = 2'd1;
    localparam logic [1:0] st_amo_wait = 2'd2;
    localparam logic [1:0] st_write    = 2'd3;
    localparam int rd_cnt_w = 4;

    logic [1:0]             state;
    logic [rd_cnt_w-1:0]    rd_outstanding;
    logic                   ar_fire;
    logic                   r_done;
    logic                   read_start;
    logic                   amo_start;
    logic                   write_start;
    logic [`L2_BURST_W:0]   beats;
    l2_axi_pkg::word_addr_t burst_base;
    l2_axi_pkg::word_t      amo_result;
    l2_axi_pkg::word_t      amo_result_q;

    assign ar_fire = arvalid && arready;
    assign r_done  = rvalid && rlast;

    // plain reads may pile up, writes and atomics wait for the read channel to drain
    assign read_start  = head_valid && !head_is_amo && head_rnw && (rd_outstanding != '1);
    assign amo_start   = head_valid && head_is_amo && (rd_outstanding == '0);
    assign write_start = head_valid && !head_is_amo && !head_rnw && (rd_outstanding == '0);

    // burst starts at the address rounded down to a multiple of its beat count
    assign beats      = {1'b0, head_ctrl.burst_len} + 1'b1;
    assign burst_base = head_addr - (head_addr % l2_axi_pkg::word_addr_t'(beats));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (read_start || amo_start) begin
                        state   <= st_ar;
                        arvalid <= 1'b1;
                    end else if (write_start) begin
                        state   <= st_write;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                st_ar: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        state   <= head_is_amo ? st_amo_wait : st_idle;
                    end
                end
                st_amo_wait: begin
                    // only the atomic read is in flight here
                    if (rvalid) begin
                        state   <= st_write;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end
                end
                default: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_outstanding <= '0;
        end else if (ar_fire && !r_done) begin
            rd_outstanding <= rd_outstanding + 1'b1;
        end else if (!ar_fire && r_done) begin
            rd_outstanding <= rd_outstanding - 1'b1;
        end
    end

    amo_alu alu (
        .op      (head_ctrl.amo_op),
        .loaded  (rdata),
        .operand (head_wdata),
        .result  (amo_result)
    );

    always_ff @(posedge clk) begin
        if (state == st_amo_wait && rvalid) begin
            amo_result_q <= amo_result;
        end
    end

    // reads retire at address handshake, writes and atomics at the write response
    assign pop = (ar_fire && !head_is_amo) || (state == st_write && bvalid);

    assign araddr = {(head_is_amo ? head_addr : burst_base), 2'b00};
    assign arlen  = head_is_amo ? 8'd0 : 8'(head_ctrl.burst_len);
    assign arid   = head_id;

    assign awaddr = {head_addr, 2'b00};
    assign awlen  = 8'd0;
    assign wdata  = head_is_amo ? amo_result_q : head_wdata;
    assign wstrb  = head_is_amo ? 4'hf : head_be;
    assign wlast  = wvalid;

    // read beats go straight back, atomics return the old word
    assign rd_valid = rvalid;
    assign rd_data  = rdata;
    assign rd_id    = rid;
    assign rd_last  = rlast;

    // valid and its payload hold until the slave takes them
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
            && $stable(arid));
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

    // slave must not return data nobody asked for
    r_expected: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rd_outstanding != '0);

endmodule

// ==== source/l2_axi_top.sv ====
// Top level of the L2-to-AXI bridge, connects the request queue to the AXI issue stage
module l2_axi_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_rnw,
    input  logic                   req_is_amo,
    input  l2_axi_pkg::word_addr_t req_addr,
    input  l2_axi_pkg::req_ctrl_u  req_ctrl,
    input  l2_axi_pkg::word_t      req_wdata,
    input  logic [3:0]             req_be,
    input  l2_axi_pkg::l2_id_t     req_id,
    output logic                   credit_return,
    input  logic                   arready,
    output logic                   arvalid,
    output logic [31:0]            araddr,
    output logic [7:0]             arlen,
    output l2_axi_pkg::l2_id_t     arid,
    input  logic                   rvalid,
    input  l2_axi_pkg::word_t      rdata,
    input  l2_axi_pkg::l2_id_t     rid,
    input  logic                   rlast,
    input  logic                   awready,
    output logic                   awvalid,
    output logic [31:0]            awaddr,
    output logic [7:0]             awlen,
    input  logic                   wready,
    output logic                   wvalid,
    output l2_axi_pkg::word_t      wdata,
    output logic [3:0]             wstrb,
    output logic                   wlast,
    input  logic                   bvalid,
    output logic                   rd_valid,
    output l2_axi_pkg::word_t      rd_data,
    output l2_axi_pkg::l2_id_t     rd_id,
    output logic                   rd_last
);
    // queue head as seen by the issue stage
    logic                   head_valid;
    logic                   head_rnw;
    logic                   head_is_amo;
    l2_axi_pkg::word_addr_t head_addr;
    l2_axi_pkg::req_ctrl_u  head_ctrl;
    l2_axi_pkg::word_t      head_wdata;
    logic [3:0]             head_be;
    l2_axi_pkg::l2_id_t     head_id;
    logic                   pop;

    l2_request_queue queue (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_rnw       (req_rnw),
        .req_is_amo    (req_is_amo),
        .req_addr      (req_addr),
        .req_ctrl      (req_ctrl),
        .req_wdata     (req_wdata),
        .req_be        (req_be),
        .req_id        (req_id),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_rnw      (head_rnw),
        .head_is_amo   (head_is_amo),
        .head_addr     (head_addr),
        .head_ctrl     (head_ctrl),
        .head_wdata    (head_wdata),
        .head_be       (head_be),
        .head_id       (head_id),
        .credit_return (credit_return)
    );

    l2_axi_issue issue (
        .clk         (clk),
        .rst         (rst),
        .head_valid  (head_valid),
        .head_rnw    (head_rnw),
        .head_is_amo (head_is_amo),
        .head_addr   (head_addr),
        .head_ctrl   (head_ctrl),
        .head_wdata  (head_wdata),
        .head_be     (head_be),
        .head_id     (head_id),
        .pop         (pop),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arid        (arid),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rid         (rid),
        .rlast       (rlast),
        .awready     (awready),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .wready      (wready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .bvalid      (bvalid),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_id       (rd_id),
        .rd_last     (rd_last)
    );

endmodule

// ==== tb/axi_mem_model.sv ====
// AXI slave memory model for the bridge testbench, random ready delays and in-order responses
module axi_mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [31:0]            araddr,
    input  logic [7:0]             arlen,
    input  l2_axi_pkg::l2_id_t     arid,
    output logic                   rvalid,
    output l2_axi_pkg::word_t      rdata,
    output l2_axi_pkg::l2_id_t     rid,
    output logic                   rlast,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  l2_axi_pkg::word_t      wdata,
    input  logic [3:0]             wstrb,
    output logic                   bvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    l2_axi_pkg::word_t mem [256];
    integer seed;
    int ar_delay;
    int aw_delay;
    int w_delay;
    int beat;
    int q_addr [$];
    int q_len [$];
    l2_axi_pkg::l2_id_t q_id [$];
    logic aw_got;
    logic w_got;
    int wr_addr;
    l2_axi_pkg::word_t wr_data;
    logic [3:0] wr_strb;

    initial begin
        seed = 86;
        for (int i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            bvalid  <= 1'b0;
            ar_delay = 0;
            aw_delay = 0;
            w_delay  = 0;
            beat     = 0;
            aw_got   = 1'b0;
            w_got    = 1'b0;
            q_addr.delete();
            q_len.delete();
            q_id.delete();
        end else begin
            // address channel, ready comes after 0 to 3 idle cycles
            if (arvalid && arready) begin
                q_addr.push_back(int'(araddr[9:2]));
                q_len.push_back(int'(arlen));
                q_id.push_back(arid);
                arready <= 1'b0;
                ar_delay = $random(seed) & 3;
            end else if (ar_delay == 0) begin
                arready <= 1'b1;
            end else begin
                ar_delay = ar_delay - 1;
            end

            // one beat per cycle, oldest burst first
            if (q_addr.size() > 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[(q_addr[0] + beat) & 255];
                rid    <= q_id[0];
                rlast  <= (beat == q_len[0]);
                if (beat == q_len[0]) begin
                    void'(q_addr.pop_front());
                    void'(q_len.pop_front());
                    void'(q_id.pop_front());
                    beat = 0;
                end else begin
                    beat = beat + 1;
                end
            end else begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end

            if (awvalid && awready) begin
                wr_addr = int'(awaddr[9:2]);
                aw_got  = 1'b1;
                awready <= 1'b0;
                aw_delay = $random(seed) & 3;
            end else if (aw_delay == 0) begin
                awready <= 1'b1;
            end else begin
                aw_delay = aw_delay - 1;
            end

            if (wvalid && wready) begin
                wr_data = wdata;
                wr_strb = wstrb;
                w_got   = 1'b1;
                wready <= 1'b0;
                w_delay = $random(seed) & 3;
            end else if (w_delay == 0) begin
                wready <= 1'b1;
            end else begin
                w_delay = w_delay - 1;
            end

            // write lands once address and data are both in
            bvalid <= 1'b0;
            if (aw_got && w_got) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr][8*b +: 8] = wr_data[8*b +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
                bvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== tb/l2_axi_tb.sv ====
// Testbench for the L2-to-AXI bridge that runs a request table against a random-delay AXI memory
`include "l2_axi_defines.svh"

module l2_axi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        int         kind;
        int         addr;
        int         ctrl;
        logic [31:0] wdata;
        logic [3:0] be;
        int         id;
    } entry_t;

    localparam int k_read = 0;
    localparam int k_write = 1;
    localparam int k_amo = 2;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_rnw;
    logic req_is_amo;
    l2_axi_pkg::word_addr_t req_addr;
    l2_axi_pkg::req_ctrl_u req_ctrl;
    l2_axi_pkg::word_t req_wdata;
    logic [3:0] req_be;
    l2_axi_pkg::l2_id_t req_id;
    logic credit_return;
    logic arready, arvalid, rvalid, rlast, awready, awvalid, wready, wvalid, wlast, bvalid;
    logic [31:0] araddr;
    logic [31:0] awaddr;
    logic [7:0] arlen;
    logic [7:0] awlen;
    l2_axi_pkg::l2_id_t arid;
    l2_axi_pkg::l2_id_t rid;
    l2_axi_pkg::word_t rdata;
    l2_axi_pkg::word_t wdata;
    logic [3:0] wstrb;
    logic rd_valid;
    logic rd_last;
    l2_axi_pkg::word_t rd_data;
    l2_axi_pkg::l2_id_t rd_id;

    entry_t table_q [$];
    l2_axi_pkg::word_t shadow [256];
    integer seed;
    int credits;
    int returned;
    int checks;
    int errors;
    int ret_entry [$];
    l2_axi_pkg::word_t exp_data [$];
    l2_axi_pkg::l2_id_t exp_id [$];
    logic exp_last [$];
    int exp_entry [$];

    l2_axi_top uut (.*);

    axi_mem_model slave (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input l2_axi_pkg::word_t got,
                              input l2_axi_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input l2_axi_pkg::l2_id_t got,
                            input l2_axi_pkg::l2_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // new memory word for each atomic opcode
    function automatic l2_axi_pkg::word_t amo_expect(input int op, input l2_axi_pkg::word_t old,
                                                     input l2_axi_pkg::word_t opnd);
        case (op)
            1: return old + opnd;
            2: return old & opnd;
            3: return old | opnd;
            4: return old ^ opnd;
            5: return ($signed(old) < $signed(opnd)) ? old : opnd;
            6: return ($signed(old) > $signed(opnd)) ? old : opnd;
            7: return (old < opnd) ? old : opnd;
            8: return (old > opnd) ? old : opnd;
            default: return opnd;
        endcase
    endfunction

    task automatic add_entry(input int kind, input int addr, input int ctrl,
                             input logic [31:0] data, input logic [3:0] be, input int id);
        entry_t e;
        e.kind  = kind;
        e.addr  = addr;
        e.ctrl  = ctrl;
        e.wdata = data;
        e.be    = be;
        e.id    = id;
        table_q.push_back(e);
    endtask

    task automatic send_entry(input int n);
        entry_t e;
        int waited;
        int base;
        l2_axi_pkg::word_t old;
        e = table_q[n];
        waited = 0;
        while (credits == 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 500) begin
                $display("timeout waiting for a credit before entry %0d", n);
                $display("sim failed");
                $finish;
            end
        end
        req_valid          = 1'b1;
        req_rnw            = (e.kind != k_write);
        req_is_amo         = (e.kind == k_amo);
        req_addr           = l2_axi_pkg::word_addr_t'(e.addr);
        req_ctrl.burst_len = 4'(e.ctrl);
        req_wdata          = e.wdata;
        req_be             = e.be;
        req_id             = l2_axi_pkg::l2_id_t'(e.id);
        credits--;
        ret_entry.push_back(n);
        // expected responses follow table order
        if (e.kind == k_read) begin
            base = e.addr - (e.addr % (e.ctrl + 1));
            for (int k = 0; k <= e.ctrl; k++) begin
                exp_data.push_back(shadow[(base + k) & 255]);
                exp_id.push_back(l2_axi_pkg::l2_id_t'(e.id));
                exp_last.push_back(k == e.ctrl);
                exp_entry.push_back(n);
            end
        end else if (e.kind == k_amo) begin
            old = shadow[e.addr];
            exp_data.push_back(old);
            exp_id.push_back(l2_axi_pkg::l2_id_t'(e.id));
            exp_last.push_back(1'b1);
            exp_entry.push_back(n);
            shadow[e.addr] = amo_expect(e.ctrl, old, e.wdata);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (e.be[b]) begin
                    shadow[e.addr][8*b +: 8] = e.wdata[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    // credits come back in table order
    always @(posedge clk) begin
        if (!rst && credit_return) begin
            credits++;
            returned++;
            if (credits > `L2_QUEUE_DEPTH || ret_entry.size() == 0) begin
                errors++;
                $display("credit returned with no request outstanding");
            end else if (table_q[ret_entry[0]].kind == k_write) begin
                $display("entry %0d write done", ret_entry.pop_front());
            end else begin
                void'(ret_entry.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && rd_valid) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("read beat arrived with none expected");
            end else begin
                check_word("rd_data", rd_data, exp_data.pop_front());
                check_id("rd_id", rd_id, exp_id.pop_front());
                check_word("rd_last", l2_axi_pkg::word_t'(rd_last),
                           l2_axi_pkg::word_t'(exp_last[0]));
                if (exp_last.pop_front()) begin
                    $display("entry %0d read done", exp_entry[0]);
                end
                void'(exp_entry.pop_front());
            end
        end
    end

    // every write is a single beat
    always @(posedge clk) begin
        if (!rst && awvalid) begin
            check_word("awlen", l2_axi_pkg::word_t'(awlen), 32'd0);
        end
        if (!rst && wvalid) begin
            check_word("wlast", l2_axi_pkg::word_t'(wlast), 32'd1);
        end
    end

    initial begin
        int waited;
        logic [31:0] operands [9];
        seed = 86;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = $random(seed);
        end
        rst = 1'b1;
        req_valid = 1'b0;
        req_rnw = 1'b0;
        req_is_amo = 1'b0;
        req_addr = '0;
        req_ctrl = '0;
        req_wdata = '0;
        req_be = '0;
        req_id = '0;
        credits = `L2_QUEUE_DEPTH;
        returned = 0;
        checks = 0;
        errors = 0;

        add_entry(k_read, 8, 0, 0, 4'h0, 1);
        add_entry(k_read, 21, 1, 0, 4'h0, 2);
        add_entry(k_read, 37, 3, 0, 4'h0, 3);
        add_entry(k_read, 70, 7, 0, 4'h0, 4);
        add_entry(k_read, 130, 15, 0, 4'h0, 5);
        add_entry(k_write, 40, 0, 32'hdeadbeef, 4'b0101, 6);
        add_entry(k_read, 40, 0, 0, 4'h0, 7);
        add_entry(k_write, 41, 0, 32'h12345678, 4'b1000, 8);
        add_entry(k_read, 41, 0, 0, 4'h0, 9);
        operands = '{32'h0000abcd, 32'h00000005, 32'hf0f0f0f0, 32'h0000ff00, 32'h5a5a5a5a,
                     32'h80000001, 32'h7ffffff0, 32'h10000000, 32'h90000000};
        for (int op = 0; op < 9; op++) begin
            add_entry(k_amo, 50 + op, op, operands[op], 4'hf, 10 + op % 6);
            add_entry(k_read, 50 + op, 0, 0, 4'h0, op);
        end
        // overlapping mixed traffic
        add_entry(k_write, 60, 0, 32'hcafef00d, 4'hf, 1);
        add_entry(k_amo, 60, 1, 32'h00000011, 4'hf, 2);
        add_entry(k_read, 61, 3, 0, 4'h0, 3);
        add_entry(k_write, 61, 0, 32'h0badc0de, 4'b0110, 4);
        add_entry(k_amo, 62, 6, 32'h00001000, 4'hf, 5);
        add_entry(k_read, 63, 1, 0, 4'h0, 6);
        add_entry(k_write, 63, 0, 32'h87654321, 4'b0011, 7);
        add_entry(k_read, 60, 3, 0, 4'h0, 8);

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int n = 0; n < table_q.size(); n++) begin
            send_entry(n);
        end

        // drained once every beat is checked and every request has its credit
        waited = 0;
        while (exp_data.size() != 0 || ret_entry.size() != 0) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 2000) begin
                $display("timeout waiting for responses and credits to drain");
                $display("sim failed");
                $finish;
            end
        end
        check_word("credits", l2_axi_pkg::word_t'(credits), `L2_QUEUE_DEPTH);
        check_word("credit_returns", l2_axi_pkg::word_t'(returned),
                   l2_axi_pkg::word_t'(table_q.size()));

        $display("%0d entries, %0d checks, %0d errors", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== l2_axi_top.f ====
+incdir+source
source/l2_axi_pkg.sv
source/l2_request_queue.sv
source/amo_alu.sv
source/l2_axi_issue.sv
source/l2_axi_top.sv
tb/axi_mem_model.sv
tb/l2_axi_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f l2_axi_top.f --top-module l2_axi_tb -o l2_axi_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/l2_axi_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^sim passed$" <<< "$output"; then
    exit 0
fi
exit 1
